//--- all.f
design/tlp_pkg.sv
design/mmio_pkg.sv
design/mmio_req_decode.sv
design/mmio_csr_bank.sv
design/mmio_tag_table.sv
design/mmio_cpl_gen.sv
design/mmio_host_chan.sv
verif/mmio_host_chan_properties.sv
verif/mmio_host_chan_tb.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, then search the log for the pass message
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module mmio_host_chan_tb \
    -f all.f --Mdir obj_dir -o mmio_host_chan_sim > build.log 2>&1 ||
    { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/mmio_host_chan_sim > sim.log 2>&1
grep -q "All tests passed" sim.log && echo "Simulation passed" ||
    { echo "Simulation failed, see sim.log"; exit 1; }

//--- verif/mmio_host_chan_tb.sv
////////////////////////////////////////////////////////////
// Testbench for the MMIO host channel: stimulus table,
// register model, rx driver, tx monitor and run summary
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module mmio_host_chan_tb;
    import tlp_pkg::*;

    localparam int NUM_CSRS       = 16;
    localparam int MAX_READS      = 32;
    localparam int NUM_ENTRIES    = 25;
    localparam int NUM_GROUPS     = 5;
    localparam int TIMEOUT_CYCLES = NUM_ENTRIES * 20 + 100;

    // One row of the stimulus table with its expected completion
    typedef struct packed {
        logic [2:0]   grp;
        tlp_fmttype_e fmttype;
        logic [31:0]  addr;
        logic [31:0]  data;
        logic [7:0]   tag;
        logic [15:0]  rid;
        logic [2:0]   tc;
        logic         poison;
        logic         exp_cpl;
        logic [31:0]  exp_data;
    } stim_t;

    logic      clk;
    logic      reset_n;
    logic      rx_valid;
    logic      rx_ready;
    tlp_beat_t rx;
    logic      tx_valid;
    logic      tx_ready;
    tlp_beat_t tx;

    stim_t       stim [NUM_ENTRIES];
    int          n_entries;
    logic [31:0] model [NUM_CSRS];
    tlp_beat_t   exp_q [$];
    logic [31:0] rng;
    int          cycles;
    int          err_count;
    int          check_count;
    int          grp_err_start;
    int          pass_tests;
    int          fail_tests;

    mmio_host_chan #(
        .MAX_READS(MAX_READS),
        .NUM_CSRS (NUM_CSRS)
    ) UUT (
        .clk, .reset_n,
        .rx_valid, .rx_ready, .rx,
        .tx_valid, .tx_ready, .tx
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // The host takes a completion in roughly three cycles out of four
    initial
    begin
        rng      = 32'h14cc_add4;
        tx_ready = 1'b0;
        forever
        begin
            @(posedge clk);
            #2;
            rng      = xorshift32(rng);
            tx_ready = (rng[3:2] != 2'b00);
        end
    end

    // The run stops at a hard cycle limit in case a handshake never completes
    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("Timeout after %0d cycles with %0d completions still missing",
                     cycles, exp_q.size());
            $display("Some tests failed");
            $finish;
        end
    end

    function automatic string group_name(input int g);
        case (g)
            1:       return "read of unwritten registers";
            2:       return "write then read back";
            3:       return "address aliasing";
            4:       return "dropped TLPs";
            default: return "read burst under back-pressure";
        endcase
    endfunction

    // Appends one row and updates the register model as the bank would
    task automatic add_entry(input int grp, input tlp_fmttype_e fmt,
                             input logic [31:0] addr, input logic [31:0] data,
                             input logic [7:0] tag, input logic [15:0] rid,
                             input logic [2:0] tc, input logic poison);
        stim_t e;
        int    idx;
        idx       = int'((addr >> 2) % NUM_CSRS);
        e         = '0;
        e.grp     = 3'(grp);
        e.fmttype = fmt;
        e.addr    = addr;
        e.data    = data;
        e.tag     = tag;
        e.rid     = rid;
        e.tc      = tc;
        e.poison  = poison;
        // Only clean reads complete, and only clean writes land
        if (fmt == FMT_MRD32 && !poison)
        begin
            e.exp_cpl  = 1'b1;
            e.exp_data = model[idx];
        end
        if (fmt == FMT_MWR32 && !poison)
            model[idx] = data;
        stim[n_entries] = e;
        n_entries++;
    endtask

    task automatic build_stimulus();
        for (int i = 0; i < NUM_CSRS; i++)
        begin
            model[i] = '0;
        end
        n_entries = 0;
        // Unwritten registers where the second read also sets high address bits
        add_entry(1, FMT_MRD32, 32'h0000_0014, 32'h0, 8'h01, 16'h0100, 3'd0, 1'b0);
        add_entry(1, FMT_MRD32, 32'h1000_007c, 32'h0, 8'h02, 16'habcd, 3'd5, 1'b0);
        add_entry(2, FMT_MWR32, 32'h0000_0008, 32'hdead_beef, 8'h00, 16'h0101, 3'd0, 1'b0);
        add_entry(2, FMT_MRD32, 32'h0000_0008, 32'h0, 8'h03, 16'h0102, 3'd1, 1'b0);
        add_entry(2, FMT_MWR32, 32'h0000_0020, 32'h1234_5678, 8'h00, 16'h0103, 3'd0, 1'b0);
        add_entry(2, FMT_MWR32, 32'h0000_0024, 32'h0bad_f00d, 8'h00, 16'h0104, 3'd0, 1'b0);
        add_entry(2, FMT_MRD32, 32'h0000_0020, 32'h0, 8'h04, 16'h0105, 3'd2, 1'b0);
        add_entry(2, FMT_MRD32, 32'h0000_0024, 32'h0, 8'h05, 16'h0106, 3'd3, 1'b0);
        // Word 19 aliases onto word 3, word 36 onto word 4
        add_entry(3, FMT_MWR32, 32'h0000_000c, 32'ha5a5_0003, 8'h00, 16'h0200, 3'd0, 1'b0);
        add_entry(3, FMT_MRD32, 32'h0000_004c, 32'h0, 8'h06, 16'h0201, 3'd4, 1'b0);
        add_entry(3, FMT_MWR32, 32'h0000_0090, 32'h5a5a_0004, 8'h00, 16'h0202, 3'd0, 1'b0);
        add_entry(3, FMT_MRD32, 32'h0000_0010, 32'h0, 8'h07, 16'h0203, 3'd6, 1'b0);
        // None of these may touch word 3
        add_entry(4, FMT_MWR32, 32'h0000_000c, 32'hffff_ffff, 8'h00, 16'h0300, 3'd0, 1'b1);
        add_entry(4, FMT_MSG,   32'h0000_000c, 32'h0000_1111, 8'h00, 16'h0301, 3'd0, 1'b0);
        add_entry(4, FMT_CPLD,  32'h0000_000c, 32'h0000_2222, 8'h0b, 16'h0302, 3'd0, 1'b0);
        add_entry(4, FMT_MRD32, 32'h0000_000c, 32'h0, 8'h08, 16'h0303, 3'd7, 1'b1);
        add_entry(4, FMT_MRD32, 32'h0000_000c, 32'h0, 8'h09, 16'h0304, 3'd1, 1'b0);
        // Burst tags keep their upper bits so the full host tag is checked
        for (int i = 0; i < 8; i++)
        begin
            add_entry(5, FMT_MRD32, 32'(i) * 32'h24, 32'h0, 8'hc0 + 8'(i + 10),
                      16'h2000 + 16'(i), 3'(i), 1'b0);
        end
    endtask

    function automatic tlp_beat_t make_request(input stim_t e);
        tlp_beat_t b;
        b                  = '0;
        b.hdr.fmttype      = e.fmttype;
        b.hdr.length       = 10'd1;
        b.hdr.requester_id = e.rid;
        b.hdr.tag          = e.tag;
        b.hdr.tc           = e.tc;
        b.hdr.addr         = e.addr;
        b.hdr.poison       = e.poison;
        b.data             = e.data;
        return b;
    endfunction

    // A one-DW CplD echoes the request fields and carries four bytes
    function automatic tlp_beat_t make_completion(input stim_t e);
        tlp_beat_t b;
        b                  = '0;
        b.hdr.fmttype      = FMT_CPLD;
        b.hdr.length       = 10'd1;
        b.hdr.requester_id = e.rid;
        b.hdr.tag          = e.tag;
        b.hdr.tc           = e.tc;
        b.hdr.lower_addr   = e.addr[6:0];
        b.hdr.byte_count   = 12'd4;
        b.data             = e.exp_data;
        return b;
    endfunction

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp, input logic [7:0] tag);
        check_count++;
        if (got !== exp)
        begin
            err_count++;
            $display("ERR %s got %h expected %h (tag %h)", name, got, exp, tag);
        end
    endtask

    task automatic check_completion(input tlp_beat_t got);
        tlp_beat_t exp;
        if (exp_q.size() == 0)
        begin
            err_count++;
            $display("A completion with tag %h and data %h arrived when none was expected",
                     got.hdr.tag, got.data);
        end
        else
        begin
            exp = exp_q.pop_front();
            compare_field("tx.hdr.fmttype", 32'(got.hdr.fmttype), 32'(exp.hdr.fmttype),
                          exp.hdr.tag);
            compare_field("tx.hdr.length", 32'(got.hdr.length), 32'(exp.hdr.length),
                          exp.hdr.tag);
            compare_field("tx.hdr.requester_id", 32'(got.hdr.requester_id),
                          32'(exp.hdr.requester_id), exp.hdr.tag);
            compare_field("tx.hdr.tag", 32'(got.hdr.tag), 32'(exp.hdr.tag), exp.hdr.tag);
            compare_field("tx.hdr.tc", 32'(got.hdr.tc), 32'(exp.hdr.tc), exp.hdr.tag);
            compare_field("tx.hdr.addr", got.hdr.addr, exp.hdr.addr, exp.hdr.tag);
            compare_field("tx.hdr.lower_addr", 32'(got.hdr.lower_addr),
                          32'(exp.hdr.lower_addr), exp.hdr.tag);
            compare_field("tx.hdr.byte_count", 32'(got.hdr.byte_count),
                          32'(exp.hdr.byte_count), exp.hdr.tag);
            compare_field("tx.hdr.poison", 32'(got.hdr.poison), 32'(exp.hdr.poison),
                          exp.hdr.tag);
            compare_field("tx.data", got.data, exp.data, exp.hdr.tag);
        end
    endtask

    // Outputs are sampled mid-cycle well clear of both edges
    always @(negedge clk)
    begin
        if (reset_n && tx_valid && tx_ready)
            check_completion(tx);
    end

    // Called 2 ns after a rising edge and returns at the same point
    task automatic send_beat(input tlp_beat_t b);
        rx       = b;
        rx_valid = 1'b1;
        @(negedge clk);
        while (!rx_ready)
        begin
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        rx_valid = 1'b0;
    endtask

    task automatic finish_group(input int g);
        int errs;
        while (exp_q.size() != 0)
        begin
            @(negedge clk);
        end
        // A few idle cycles let any stray completion show up
        repeat (4) @(negedge clk);
        errs = err_count - grp_err_start;
        if (errs == 0)
        begin
            pass_tests++;
            $display("Test %0d (%s): PASS", g, group_name(g));
        end
        else
        begin
            fail_tests++;
            $display("Test %0d (%s): FAIL with %0d errors", g, group_name(g), errs);
        end
        grp_err_start = err_count;
        @(posedge clk);
        #2;
    endtask

    initial
    begin
        int cur_grp;
        rx_valid      = 1'b0;
        rx            = '0;
        reset_n       = 1'b0;
        err_count     = 0;
        check_count   = 0;
        grp_err_start = 0;
        pass_tests    = 0;
        fail_tests    = 0;
        build_stimulus();
        repeat (5) @(posedge clk);
        #2;
        reset_n = 1'b1;

        cur_grp = int'(stim[0].grp);
        for (int i = 0; i < n_entries; i++)
        begin
            if (int'(stim[i].grp) != cur_grp)
            begin
                finish_group(cur_grp);
                cur_grp = int'(stim[i].grp);
            end
            // Queue the completion before the request can produce it
            if (stim[i].exp_cpl)
                exp_q.push_back(make_completion(stim[i]));
            send_beat(make_request(stim[i]));
        end
        finish_group(cur_grp);

        $display("Summary: %0d of %0d tests passed, %0d checks, %0d errors",
                 pass_tests, NUM_GROUPS, check_count, err_count);
        if (err_count == 0 && fail_tests == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

//--- verif/mmio_host_chan_properties.sv
////////////////////////////////////////////////////////////
// Concurrent assertions on read tag use and the tx stream,
// bound into the MMIO host channel top level
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module mmio_host_chan_properties (
    input logic                 clk,
    input logic                 reset_n,
    input logic                 meta_wen,
    input mmio_pkg::mmio_meta_t meta,
    input logic                 rsp_valid,
    input logic                 rsp_ready,
    input mmio_pkg::mmio_rsp_t  rsp,
    input logic                 tx_valid,
    input logic                 tx_ready,
    input tlp_pkg::tlp_beat_t   tx
);
    import mmio_pkg::*;

    // One bit per MMIO tag, set by a read's metadata write and
    // cleared when the completion stage accepts its response
    logic [2**TAG_W-1:0] active;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            active <= '0;
        else
        begin
            if (rsp_valid && rsp_ready)
                active[rsp.tag] <= 1'b0;
            if (meta_wen)
                active[meta.tag[TAG_W-1:0]] <= 1'b1;
        end
    end

    // A second read on a live tag would overwrite its metadata
    tag_free_on_write: assert property (@(posedge clk) disable iff (!reset_n)
        meta_wen |-> !active[meta.tag[TAG_W-1:0]])
        else $error("Read metadata written over active tag %h", meta.tag);

    rsp_tag_active: assert property (@(posedge clk) disable iff (!reset_n)
        (rsp_valid && rsp_ready) |-> active[rsp.tag])
        else $error("Response accepted for inactive tag %h", rsp.tag);

    // A stalled completion must hold still until the host takes it
    tx_hold_stable: assert property (@(posedge clk) disable iff (!reset_n)
        (tx_valid && !tx_ready) |=> (tx_valid && $stable(tx)))
        else $error("tx changed while stalled");

    tx_idle_after_reset: assert property (@(posedge clk)
        !reset_n |=> !tx_valid)
        else $error("tx_valid high in the cycle after reset");

endmodule

// Watches the decode and completion stage ports from the top level
bind mmio_host_chan mmio_host_chan_properties u_properties (
    .clk      (clk),
    .reset_n  (reset_n),
    .meta_wen (meta_wen),
    .meta     (meta),
    .rsp_valid(rsp_valid),
    .rsp_ready(rsp_ready),
    .rsp      (rsp),
    .tx_valid (tx_valid),
    .tx_ready (tx_ready),
    .tx       (tx)
);

//--- design/mmio_host_chan.sv
////////////////////////////////////////////////////////////
// Host-channel MMIO endpoint top level: decode, register
// bank, tag table and completion generator
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module mmio_host_chan #(
    // Outstanding reads, at most 2**TAG_W
    parameter int MAX_READS = 32,
    parameter int NUM_CSRS  = 16
) (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               rx_valid,
    output logic               rx_ready,
    input  tlp_pkg::tlp_beat_t rx,
    output logic               tx_valid,
    input  logic               tx_ready,
    output tlp_pkg::tlp_beat_t tx
);
    import mmio_pkg::*;

    // Decode to register bank
    logic       req_valid;
    logic       req_ready;
    mmio_req_t  req;

    // Decode to tag table
    logic       meta_wen;
    mmio_meta_t meta;

    // Register bank to completion stage
    logic       rsp_valid;
    logic       rsp_ready;
    mmio_rsp_t  rsp;

    // Completion stage lookup into the tag table
    logic             lookup_en;
    logic [TAG_W-1:0] lookup_tag;
    mmio_meta_t       lookup_meta;

    mmio_req_decode u_decode (
        .clk, .reset_n,
        .rx_valid, .rx_ready, .rx,
        .req_valid, .req_ready, .req,
        .meta_wen, .meta
    );

    mmio_csr_bank #(.NUM_CSRS(NUM_CSRS)) u_csr_bank (
        .clk, .reset_n,
        .req_valid, .req_ready, .req,
        .rsp_valid, .rsp_ready, .rsp
    );

    mmio_tag_table #(.MAX_READS(MAX_READS)) u_tag_table (
        .clk,
        .meta_wen, .meta,
        .lookup_en, .lookup_tag, .lookup_meta
    );

    mmio_cpl_gen u_cpl_gen (
        .clk, .reset_n,
        .rsp_valid, .rsp_ready, .rsp,
        .lookup_en, .lookup_tag, .lookup_meta,
        .tx_valid, .tx_ready, .tx
    );

endmodule

//--- design/mmio_cpl_gen.sv
////////////////////////////////////////////////////////////
// Completion stage: joins register bank responses with their
// stored metadata and drives CplD TLPs onto the tx stream
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module mmio_cpl_gen (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       rsp_valid,
    output logic                       rsp_ready,
    input  mmio_pkg::mmio_rsp_t        rsp,
    output logic                       lookup_en,
    output logic [mmio_pkg::TAG_W-1:0] lookup_tag,
    input  mmio_pkg::mmio_meta_t       lookup_meta,
    output logic                       tx_valid,
    input  logic                       tx_ready,
    output tlp_pkg::tlp_beat_t         tx
);
    import tlp_pkg::*;

    // Join slot holds the response payload while its metadata
    // comes back from the tag table one cycle after the lookup
    logic        join_valid;
    logic [31:0] join_data;
    logic        join_move;
    logic        tx_free;
    tlp_hdr_t    cpl_hdr;

    assign tx_free   = !tx_valid || tx_ready;
    assign join_move = join_valid && tx_free;

    // A response enters when the slot is empty or draining this cycle
    assign rsp_ready = !join_valid || join_move;

    // The lookup fires only on acceptance, so lookup_meta belongs to
    // whatever currently sits in the join slot
    assign lookup_en  = rsp_valid && rsp_ready;
    assign lookup_tag = rsp.tag;

    always_comb
    begin
        cpl_hdr              = '0;
        cpl_hdr.fmttype      = FMT_CPLD;
        // Length in DW is the byte count over four
        cpl_hdr.length       = lookup_meta.byte_count[11:2];
        cpl_hdr.byte_count   = lookup_meta.byte_count;
        cpl_hdr.requester_id = lookup_meta.requester_id;
        cpl_hdr.tc           = lookup_meta.tc;
        cpl_hdr.lower_addr   = lookup_meta.lower_addr;
        // The full host tag comes from the metadata, not the short MMIO tag
        cpl_hdr.tag          = lookup_meta.tag;
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            join_valid <= 1'b0;
            tx_valid   <= 1'b0;
        end
        else
        begin
            if (rsp_ready)
                join_valid <= rsp_valid;
            // Output register only changes when it is empty or taken
            if (tx_free)
                tx_valid <= join_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (lookup_en)
            join_data <= rsp.payload;
    end

    // Header and data are loaded together as the join slot drains
    always_ff @(posedge clk)
    begin
        if (join_move)
        begin
            tx.hdr  <= cpl_hdr;
            tx.data <= join_data;
        end
    end

endmodule

//--- design/mmio_tag_table.sv
////////////////////////////////////////////////////////////
// Tag-indexed read metadata memory with one write port and
// one registered, enable-gated read port
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module mmio_tag_table #(
    parameter int MAX_READS = 32
) (
    input  logic                          clk,
    input  logic                          meta_wen,
    input  mmio_pkg::mmio_meta_t          meta,
    input  logic                          lookup_en,
    input  logic [mmio_pkg::TAG_W-1:0]    lookup_tag,
    output mmio_pkg::mmio_meta_t          lookup_meta
);
    import mmio_pkg::*;

    // MAX_READS is a power of two no larger than 2**TAG_W,
    // so the low tag bits select the entry directly
    localparam int AW = (MAX_READS > 1) ? $clog2(MAX_READS) : 1;

    mmio_meta_t mem [MAX_READS];

    // Entries are written at the tag carried inside the metadata
    always_ff @(posedge clk)
    begin
        if (meta_wen)
            mem[meta.tag[AW-1:0]] <= meta;
    end

    // Read result stays put while the completion stage stalls
    always_ff @(posedge clk)
    begin
        if (lookup_en)
            lookup_meta <= mem[lookup_tag[AW-1:0]];
    end

endmodule

//--- design/mmio_csr_bank.sv
////////////////////////////////////////////////////////////
// Control/status register bank acting as the AFU: executes
// MMIO writes and returns tagged read responses
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module mmio_csr_bank #(
    parameter int NUM_CSRS = 16
) (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                req_valid,
    output logic                req_ready,
    input  mmio_pkg::mmio_req_t req,
    output logic                rsp_valid,
    input  logic                rsp_ready,
    output mmio_pkg::mmio_rsp_t rsp
);
    localparam int IDX_W = (NUM_CSRS > 1) ? $clog2(NUM_CSRS) : 1;

    logic [31:0]      regs [NUM_CSRS];
    logic [IDX_W-1:0] csr_idx;
    logic             req_take;

    // Word addresses past the bank alias back onto it
    assign csr_idx = IDX_W'(req.addr % NUM_CSRS);

    // A pending response blocks new requests until the host side takes it
    assign req_ready = !rsp_valid || rsp_ready;
    assign req_take  = req_valid && req_ready;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            rsp_valid <= 1'b0;
            for (int i = 0; i < NUM_CSRS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else
        begin
            // Writes answer nothing, so only reads raise rsp_valid
            if (req_ready)
                rsp_valid <= req_valid && !req.is_write;
            if (req_take && req.is_write)
                regs[csr_idx] <= req.payload;
        end
    end

    // The response holds still while rsp_valid waits on rsp_ready
    always_ff @(posedge clk)
    begin
        if (req_take && !req.is_write)
        begin
            rsp.tag     <= req.tag;
            rsp.payload <= regs[csr_idx];
        end
    end

endmodule

//--- design/mmio_req_decode.sv
////////////////////////////////////////////////////////////
// RX decode stage: filters memory requests out of the TLP
// stream and registers MMIO requests and read metadata
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module mmio_req_decode (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 rx_valid,
    output logic                 rx_ready,
    input  tlp_pkg::tlp_beat_t   rx,
    output logic                 req_valid,
    input  logic                 req_ready,
    output mmio_pkg::mmio_req_t  req,
    output logic                 meta_wen,
    output mmio_pkg::mmio_meta_t meta
);
    import tlp_pkg::*;
    import mmio_pkg::*;

    logic is_rd;
    logic is_mem;
    logic rx_take;

    // Only unpoisoned 32-bit memory reads and writes reach the bank
    assign is_rd  = (rx.hdr.fmttype == FMT_MRD32);
    assign is_mem = (is_rd || (rx.hdr.fmttype == FMT_MWR32)) && !rx.hdr.poison;

    // The output slot is free when empty or when the bank takes it now
    assign rx_ready = !req_valid || req_ready;
    assign rx_take  = rx_valid && rx_ready;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            req_valid <= 1'b0;
            meta_wen  <= 1'b0;
        end
        else
        begin
            // Dropped TLPs still empty the slot when it moves
            if (rx_ready)
                req_valid <= rx_valid && is_mem;
            // Metadata is written once, in the cycle req_valid rises
            meta_wen <= rx_take && is_rd && !rx.hdr.poison;
        end
    end

    // Request and metadata payload travel together
    always_ff @(posedge clk)
    begin
        if (rx_take && is_mem)
        begin
            req.tag      <= rx.hdr.tag[TAG_W-1:0];
            req.addr     <= {2'b00, rx.hdr.addr[31:2]};
            req.is_write <= !is_rd;
            req.payload  <= rx.data;

            meta.tag          <= rx.hdr.tag;
            meta.requester_id <= rx.hdr.requester_id;
            meta.tc           <= rx.hdr.tc;
            meta.lower_addr   <= rx.hdr.addr[6:0];
            meta.byte_count   <= {rx.hdr.length, 2'b00};
        end
    end

endmodule

//--- design/mmio_pkg.sv
////////////////////////////////////////////////////////////
// MMIO path definitions: tag width, request and response
// structs, and the per-tag read metadata
////////////////////////////////////////////////////////////

package mmio_pkg;

    // Tags are truncated to this width inside the MMIO path
    localparam int TAG_W = 5;

    // Request from the decode stage to the register bank
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        // Word address, byte address shifted right by two
        logic [31:0]      addr;
        logic             is_write;
        logic [31:0]      payload;
    } mmio_req_t;

    // Read answer from the register bank
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [31:0]      payload;
    } mmio_rsp_t;

    // Completion fields kept per outstanding read.
    // The full 8-bit host tag is kept so the CplD echoes it exactly
    typedef struct packed {
        logic [7:0]  tag;
        logic [15:0] requester_id;
        logic [2:0]  tc;
        logic [6:0]  lower_addr;
        logic [11:0] byte_count;
    } mmio_meta_t;

endpackage

//--- design/tlp_pkg.sv
////////////////////////////////////////////////////////////
// Host-side TLP definitions: format/type opcodes, the
// single-DW TLP header and the header-plus-data beat
////////////////////////////////////////////////////////////

package tlp_pkg;

    // Format and type share one byte, as in the TLP DW0 layout
    typedef enum logic [7:0] {
        FMT_MRD32 = 8'h00,
        FMT_MWR32 = 8'h40,
        FMT_MSG   = 8'h30,
        FMT_CPLD  = 8'h4a
    } tlp_fmttype_e;

    // One header serves requests and completions alike.
    // Requests use addr; completions use byte_count and lower_addr
    typedef struct packed {
        tlp_fmttype_e fmttype;
        // Payload length in DW
        logic [9:0]   length;
        logic [15:0]  requester_id;
        logic [7:0]   tag;
        logic [2:0]   tc;
        logic [31:0]  addr;
        logic [11:0]  byte_count;
        logic [6:0]   lower_addr;
        // Poisoned TLPs are consumed without effect
        logic         poison;
    } tlp_hdr_t;

    // Every TLP on rx and tx carries exactly one data DW
    typedef struct packed {
        tlp_hdr_t    hdr;
        logic [31:0] data;
    } tlp_beat_t;

endpackage
